//--- files.f
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/fetch_nocache.sv
logic/fetch_biu.sv
logic/fetch_top.sv
verif/fetch_tb_mem.sv
verif/fetch_tb.sv

//--- Makefile
# Verilator flow for the instruction fetch path

VERILATOR  ?= verilator
FILELIST   ?= files.f
TB_TOP     ?= fetch_tb
RTL_TOP    ?= fetch_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= NO ERRORS

SOURCES := $(shell cat $(FILELIST))
SIM_EXE := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST) --top-module $(TB_TOP)

# pass only when the pass line shows up in the output
sim: $(SIM_EXE)
	@out="$$(./$(SIM_EXE))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  import fetch_pkg::*;

  localparam int unsigned DEPTH    = 2;
  localparam int unsigned HAS_RVC  = 1;
  localparam addr_t       RESET_PC = 32'h200;
  // about ten times the length of all tests together
  localparam int unsigned TIMEOUT_CYCLES = 5000;

  logic          clk;
  logic          rst_n;
  logic          run;
  logic          flush;
  addr_t         redirect_pc;
  prv_t          st_prv;
  logic          dcflush_rdy;
  bus_req_t      bus_req;
  logic          bus_gnt;
  bus_rsp_t      bus_rsp;
  fetch_parcel_t parcel;
  // memory controls
  logic          stall_en;
  logic          err_en;
  addr_t         err_adr;

  // monitor records
  fetch_parcel_t parcels[$];
  bus_req_t      grants[$];
  int unsigned   cycle;
  int unsigned   granted;
  int unsigned   responded;
  int unsigned   req_cycles;
  logic          over_depth;
  int unsigned   errors;
  int unsigned   tests_run;
  int unsigned   tests_failed;

  always #50 clk = ~clk;

  fetch_top #(
    .DEPTH         (DEPTH),
    .HAS_RVC       (HAS_RVC),
    .RESET_PC      (RESET_PC)
  ) DUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .run_i         (run),
    .flush_i       (flush),
    .redirect_pc_i (redirect_pc),
    .st_prv_i      (st_prv),
    .dcflush_rdy_i (dcflush_rdy),
    .bus_req_o     (bus_req),
    .bus_gnt_i     (bus_gnt),
    .bus_rsp_i     (bus_rsp),
    .parcel_o      (parcel)
  );

  fetch_tb_mem u_mem (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .bus_req_i     (bus_req),
    .bus_gnt_o     (bus_gnt),
    .bus_rsp_o     (bus_rsp),
    .stall_en_i    (stall_en),
    .err_en_i      (err_en),
    .err_adr_i     (err_adr)
  );

  ////////////////////
  // reference model
  ////////////////////

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic word_t word_at(input addr_t adr);
    return lcg_next(lcg_next(adr ^ 32'd25));
  endfunction

  // good parcel whose mask starts at the parcel that pc points to
  function automatic fetch_parcel_t good_parcel(input addr_t pc);
    fetch_parcel_t p;
    p.pc         = pc;
    p.word       = word_at({pc[31:2], 2'b00});
    p.valid      = pc[1] ? 2'b10 : 2'b11;
    p.misaligned = pc[0];
    p.error      = 1'b0;
    return p;
  endfunction

  function automatic bus_req_t fetch_read(input addr_t pc, input logic priv);
    bus_req_t r;
    r.valid          = 1'b1;
    r.adr            = {pc[31:2], 2'b00};
    r.size           = WORD;
    // a start inside a word is a single transfer
    r.btype          = (pc[1:0] != 2'b00) ? SINGLE : INCR;
    r.prot.instr     = 1'b1;
    r.prot.priv      = priv;
    r.prot.cacheable = 1'b0;
    return r;
  endfunction

  ////////////////////
  // monitor
  ////////////////////

  always @(posedge clk)
  begin
    cycle++;
    if (rst_n)
    begin
      if (bus_req.valid)
        req_cycles++;
      // expected pcs are dropped on a flush
      if (flush)
        grants.delete();
      if (bus_req.valid && bus_gnt)
      begin
        granted++;
        grants.push_back(bus_req);
      end
      if (bus_rsp.valid)
        responded++;
      if (granted - responded > DEPTH)
        over_depth = 1'b1;
      if (|parcel.valid || parcel.error)
        parcels.push_back(parcel);
    end
    if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  task automatic check_parcel(input string name, input fetch_parcel_t exp,
                              input fetch_parcel_t act);
    if (act !== exp)
    begin
      $display("Error %s: parcel expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_req(input string name, input bus_req_t exp, input bus_req_t act);
    if (act !== exp)
    begin
      $display("Error %s: bus request expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_failure(input string name, input string what);
    $display("%s: %s", name, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int unsigned errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("%s: pass", name);
    else
    begin
      tests_failed++;
      $display("%s: fail with %0d mismatches", name, errors - errors_before);
    end
  endtask

  ////////////////////
  // sequencing helpers
  ////////////////////

  // monitor records settle at the rising edge and are read on the falling edge
  task automatic wait_parcels(input int unsigned n);
    while (parcels.size() < n)
      @(negedge clk);
  endtask

  task automatic wait_grants(input int unsigned n);
    while (grants.size() < n)
      @(negedge clk);
  endtask

  // flush to pc with the bus idle and then fetch
  task automatic start_at(input addr_t pc);
    @(negedge clk);
    flush       = 1'b1;
    redirect_pc = pc;
    @(negedge clk);
    flush = 1'b0;
    parcels.delete();
    run = 1'b1;
  endtask

  // stop fetching and let every read return before a falling edge
  task automatic stop_and_drain();
    @(negedge clk);
    run = 1'b0;
    while (granted != responded)
      @(negedge clk);
    @(negedge clk);
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_sequential();
    int unsigned e0;
    int unsigned i;
    e0 = errors;
    @(negedge clk);
    run = 1'b1;
    wait_parcels(8);
    for (i = 0; i < 8; i++)
    begin
      check_parcel("test_sequential", good_parcel(RESET_PC + 4 * i), parcels[i]);
      check_req("test_sequential", fetch_read(RESET_PC + 4 * i, 1'b1), grants[i]);
    end
    stop_and_drain();
    finish_test("test_sequential", e0);
  endtask

  task automatic test_backpressure();
    int unsigned e0;
    int unsigned i;
    e0 = errors;
    stall_en   = 1'b1;
    over_depth = 1'b0;
    start_at(32'h400);
    wait_parcels(12);
    for (i = 0; i < 12; i++)
      check_parcel("test_backpressure", good_parcel(32'h400 + 4 * i), parcels[i]);
    stop_and_drain();
    if (over_depth)
      report_failure("test_backpressure", "more reads were in flight than DEPTH allows");
    stall_en = 1'b0;
    finish_test("test_backpressure", e0);
  endtask

  task automatic test_flush();
    int unsigned e0;
    int unsigned i;
    e0 = errors;
    stall_en = 1'b1;
    start_at(32'h600);
    // flush only once both reads are outstanding
    while (granted - responded != DEPTH)
      @(negedge clk);
    flush       = 1'b1;
    redirect_pc = 32'h1000;
    parcels.delete();
    @(negedge clk);
    flush = 1'b0;
    wait_parcels(4);
    // any stale parcel would break this sequence
    for (i = 0; i < 4; i++)
      check_parcel("test_flush", good_parcel(32'h1000 + 4 * i), parcels[i]);
    stop_and_drain();
    stall_en = 1'b0;
    finish_test("test_flush", e0);
  endtask

  task automatic test_compressed();
    int unsigned e0;
    e0 = errors;
    start_at(32'h802);
    wait_parcels(2);
    check_parcel("test_compressed", good_parcel(32'h802), parcels[0]);
    check_req("test_compressed", fetch_read(32'h802, 1'b1), grants[0]);
    check_parcel("test_compressed", good_parcel(32'h804), parcels[1]);
    check_req("test_compressed", fetch_read(32'h804, 1'b1), grants[1]);
    stop_and_drain();
    // odd start address
    start_at(32'h901);
    wait_parcels(1);
    check_parcel("test_compressed", good_parcel(32'h901), parcels[0]);
    check_req("test_compressed", fetch_read(32'h901, 1'b1), grants[0]);
    stop_and_drain();
    finish_test("test_compressed", e0);
  endtask

  task automatic test_error();
    int unsigned   e0;
    fetch_parcel_t bad;
    e0 = errors;
    err_adr = 32'hA04;
    err_en  = 1'b1;
    start_at(32'hA00);
    wait_parcels(3);
    // error parcel carries no valid parcels and no data
    bad       = '0;
    bad.pc    = 32'hA04;
    bad.error = 1'b1;
    check_parcel("test_error", good_parcel(32'hA00), parcels[0]);
    check_parcel("test_error", bad, parcels[1]);
    check_parcel("test_error", good_parcel(32'hA08), parcels[2]);
    stop_and_drain();
    err_en = 1'b0;
    finish_test("test_error", e0);
  endtask

  task automatic test_privilege();
    int unsigned e0;
    e0 = errors;
    st_prv = PRV_U;
    start_at(32'hB00);
    wait_grants(1);
    check_req("test_privilege", fetch_read(32'hB00, 1'b0), grants[0]);
    stop_and_drain();
    st_prv = PRV_M;
    start_at(32'hC00);
    wait_grants(1);
    check_req("test_privilege", fetch_read(32'hC00, 1'b1), grants[0]);
    stop_and_drain();
    // bus stays quiet while the data side is not ready
    dcflush_rdy = 1'b0;
    start_at(32'hD00);
    req_cycles = 0;
    repeat (20) @(negedge clk);
    if (req_cycles != 0)
      report_failure("test_privilege", "a bus request appeared while dcflush_rdy_i was low");
    run         = 1'b0;
    dcflush_rdy = 1'b1;
    finish_test("test_privilege", e0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    run          = 1'b0;
    flush        = 1'b0;
    redirect_pc  = '0;
    st_prv       = PRV_M;
    dcflush_rdy  = 1'b1;
    stall_en     = 1'b0;
    err_en       = 1'b0;
    err_adr      = '0;
    cycle        = 0;
    granted      = 0;
    responded    = 0;
    req_cycles   = 0;
    over_depth   = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    test_sequential();
    test_backpressure();
    test_flush();
    test_compressed();
    test_error();
    test_privilege();
    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- verif/fetch_tb_mem.sv
`timescale 1ns/1ps

module fetch_tb_mem (
  input  logic                clk_i,
  input  logic                rst_ni,
  // read bus seen from the memory side
  input  fetch_pkg::bus_req_t bus_req_i,
  output logic                bus_gnt_o,
  output fetch_pkg::bus_rsp_t bus_rsp_o,
  // test controls
  input  logic                stall_en_i,
  input  logic                err_en_i,
  input  fetch_pkg::addr_t    err_adr_i
);

  import fetch_pkg::*;

  // granted read waiting for its response
  typedef struct packed {
    addr_t      adr;
    logic [2:0] wait_cnt;
  } pending_t;

  pending_t    pend[$];
  pending_t    entry;
  int unsigned seed      = 25;
  logic [2:0]  next_lat  = 3'd0;
  logic        stall_q   = 1'b0;
  logic        err_en_q  = 1'b0;
  addr_t       err_adr_q = '0;
  logic        gnt_q     = 1'b0;
  bus_rsp_t    rsp_q     = '0;

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // contents depend on every address bit
  function automatic word_t word_at(input addr_t adr);
    return lcg_next(lcg_next(adr ^ 32'd25));
  endfunction

  ////////////////////
  // grant capture
  ////////////////////

  always @(posedge clk_i)
  begin
    // controls change on the falling edge, take them here
    stall_q   = stall_en_i;
    err_en_q  = err_en_i;
    err_adr_q = err_adr_i;
    if (!rst_ni)
      pend.delete();
    else if (bus_req_i.valid && gnt_q)
    begin
      entry.adr      = bus_req_i.adr;
      entry.wait_cnt = next_lat;
      pend.push_back(entry);
    end
  end

  ////////////////////
  // grant and response drive
  ////////////////////

  always @(negedge clk_i)
  begin
    seed     = lcg_next(seed);
    // stalls drop roughly one grant in four
    gnt_q    = !stall_q || (seed[17:16] != 2'b00);
    // latency of 1 to 4 cycles under stalls
    next_lat = stall_q ? {1'b0, seed[21:20]} : 3'd0;
    rsp_q    = '0;
    // in order, the head blocks younger reads
    if (pend.size() != 0 && pend[0].wait_cnt == 3'd0)
    begin
      rsp_q.valid = 1'b1;
      rsp_q.err   = err_en_q && (pend[0].adr == err_adr_q);
      rsp_q.data  = rsp_q.err ? '0 : word_at(pend[0].adr);
      void'(pend.pop_front());
    end
    foreach (pend[i])
    begin
      if (pend[i].wait_cnt != 3'd0)
        pend[i].wait_cnt = pend[i].wait_cnt - 1'b1;
    end
  end

  assign bus_gnt_o = gnt_q;
  assign bus_rsp_o = rsp_q;

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
  parameter int unsigned      DEPTH    = 2,
  parameter int unsigned      HAS_RVC  = 1,
  parameter fetch_pkg::addr_t RESET_PC = 32'h200
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // core control
  input  logic                     run_i,
  input  logic                     flush_i,
  input  fetch_pkg::addr_t         redirect_pc_i,
  input  fetch_pkg::prv_t          st_prv_i,
  input  logic                     dcflush_rdy_i,
  // external read bus
  output fetch_pkg::bus_req_t      bus_req_o,
  input  logic                     bus_gnt_i,
  input  fetch_pkg::bus_rsp_t      bus_rsp_i,
  // parcels to the decoder side
  output fetch_pkg::fetch_parcel_t parcel_o
);

  import fetch_pkg::*;

  ////////////////////
  // interconnect
  ////////////////////

  // sequencer handshake
  logic       if_req;
  logic       if_ack;
  fetch_req_t fetch_req;

  // controller to bus interface
  logic       biu_stb;
  logic       biu_stb_ack;
  addr_t      biu_adri;
  biu_type_t  biu_type;
  biu_prot_t  biu_prot;

  // return path
  logic       biu_ack;
  logic       biu_err;
  addr_t      biu_adro;
  word_t      biu_q;

  ////////////////////
  // instances
  ////////////////////

  fetch_pc_gen #(
    .RESET_PC      (RESET_PC)
  ) u_pc_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .run_i         (run_i),
    .flush_i       (flush_i),
    .redirect_pc_i (redirect_pc_i),
    .st_prv_i      (st_prv_i),
    .if_ack_i      (if_ack),
    .if_req_o      (if_req),
    .req_o         (fetch_req)
  );

  fetch_nocache #(
    .DEPTH         (DEPTH),
    .HAS_RVC       (HAS_RVC)
  ) u_nocache (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .if_req_i      (if_req),
    .if_req_data_i (fetch_req),
    .if_flush_i    (flush_i),
    .dcflush_rdy_i (dcflush_rdy_i),
    .if_ack_o      (if_ack),
    .parcel_o      (parcel_o),
    .biu_stb_o     (biu_stb),
    .biu_stb_ack_i (biu_stb_ack),
    .biu_adri_o    (biu_adri),
    .biu_type_o    (biu_type),
    .biu_prot_o    (biu_prot),
    .biu_ack_i     (biu_ack),
    .biu_err_i     (biu_err),
    .biu_adro_i    (biu_adro),
    .biu_q_i       (biu_q)
  );

  fetch_biu #(
    .DEPTH         (DEPTH)
  ) u_biu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .biu_stb_i     (biu_stb),
    .biu_stb_ack_o (biu_stb_ack),
    .biu_adri_i    (biu_adri),
    .biu_type_i    (biu_type),
    .biu_prot_i    (biu_prot),
    .biu_ack_o     (biu_ack),
    .biu_err_o     (biu_err),
    .biu_adro_o    (biu_adro),
    .biu_q_o       (biu_q),
    .bus_req_o     (bus_req_o),
    .bus_gnt_i     (bus_gnt_i),
    .bus_rsp_i     (bus_rsp_i)
  );

endmodule

//--- logic/fetch_biu.sv
`timescale 1ns/1ps

module fetch_biu #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // request from the fetch controller
  input  logic                 biu_stb_i,
  output logic                 biu_stb_ack_o,
  input  fetch_pkg::addr_t     biu_adri_i,
  input  fetch_pkg::biu_type_t biu_type_i,
  input  fetch_pkg::biu_prot_t biu_prot_i,
  // response to the fetch controller
  output logic                 biu_ack_o,
  output logic                 biu_err_o,
  output fetch_pkg::addr_t     biu_adro_o,
  output fetch_pkg::word_t     biu_q_o,
  // external read bus
  output fetch_pkg::bus_req_t  bus_req_o,
  input  logic                 bus_gnt_i,
  input  fetch_pkg::bus_rsp_t  bus_rsp_i
);

  import fetch_pkg::*;

  // queue pointer width, at least one bit
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // fill level has to reach DEPTH
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  ////////////////////
  // address queue
  ////////////////////

  // addresses of granted reads, oldest at rd_ptr_q
  addr_t            adr_queue [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count_q == CNT_W'(DEPTH));
  // a read is accepted when the bus grants it
  assign push = biu_stb_ack_o;
  // responses come back in order, one per read
  assign pop  = bus_rsp_i.valid;

  // payload storage
  always_ff @(posedge clk_i)
  begin
    if (push)
      adr_queue[wr_ptr_q] <= biu_adri_i;
  end

  // pointers wrap at DEPTH
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  // fill level
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      count_q <= '0;
    else
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
  end

  ////////////////////
  // request side
  ////////////////////

  // no new read while DEPTH reads are outstanding
  always_comb
  begin
    bus_req_o.valid = biu_stb_i & ~full;
    // word aligned, the controller selects the parcels
    bus_req_o.adr   = {biu_adri_i[XLEN-1:2], 2'b00};
    bus_req_o.size  = WORD;
    bus_req_o.btype = biu_type_i;
    bus_req_o.prot  = biu_prot_i;
  end

  // grant goes back only when the read can be queued
  assign biu_stb_ack_o = biu_stb_i & ~full & bus_gnt_i;

  ////////////////////
  // response side
  ////////////////////

  // head of queue matches the response in the same cycle
  assign biu_adro_o = adr_queue[rd_ptr_q];
  assign biu_q_o    = bus_rsp_i.data;
  assign biu_ack_o  = bus_rsp_i.valid & ~bus_rsp_i.err;
  assign biu_err_o  = bus_rsp_i.valid &  bus_rsp_i.err;

endmodule

//--- logic/fetch_nocache.sv
`timescale 1ns/1ps

module fetch_nocache #(
  parameter int unsigned DEPTH   = 2,
  parameter int unsigned HAS_RVC = 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // sequencer side
  input  logic                     if_req_i,
  input  fetch_pkg::fetch_req_t    if_req_data_i,
  input  logic                     if_flush_i,
  input  logic                     dcflush_rdy_i,
  output logic                     if_ack_o,
  output fetch_pkg::fetch_parcel_t parcel_o,
  // request towards the bus interface
  output logic                     biu_stb_o,
  input  logic                     biu_stb_ack_i,
  output fetch_pkg::addr_t         biu_adri_o,
  output fetch_pkg::biu_type_t     biu_type_o,
  output fetch_pkg::biu_prot_t     biu_prot_o,
  // response from the bus interface
  input  logic                     biu_ack_i,
  input  logic                     biu_err_i,
  input  fetch_pkg::addr_t         biu_adro_i,
  input  fetch_pkg::word_t         biu_q_i
);

  import fetch_pkg::*;

  // counters must hold the value DEPTH
  localparam int unsigned CNT_W   = $clog2(DEPTH) + 1;
  // pc bits that select the first parcel
  localparam int unsigned SHIFT_W = (PARCELS > 1) ? $clog2(PARCELS) : 1;

  logic             if_flush_dly;
  logic [CNT_W-1:0] inflight;
  logic [CNT_W-1:0] discard;
  // any response, good or bad
  logic             biu_rsp;
  // response belongs to a request issued after the last flush
  logic             rsp_keep;

  assign biu_rsp = biu_ack_i | biu_err_i;

  ////////////////////
  // counters
  ////////////////////

  // flush delayed by one cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      if_flush_dly <= 1'b0;
    else
      if_flush_dly <= if_flush_i;
  end

  // reads handed to the bus and not yet answered
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight <= '0;
    else
      unique case ({biu_stb_ack_i, biu_rsp})
        2'b01:   inflight <= inflight - 1'b1;
        2'b10:   inflight <= inflight + 1'b1;
        default: inflight <= inflight;
      endcase
  end

  // responses still to drop after a flush
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard <= '0;
    else if (if_flush_i)
    begin
      // a response in the flush cycle is already gone
      if (|inflight && biu_rsp)
        discard <= inflight - 1'b1;
      else
        discard <= inflight;
    end
    else if (|discard && biu_rsp)
      discard <= discard - 1'b1;
  end

  ////////////////////
  // towards the sequencer
  ////////////////////

  assign if_ack_o = dcflush_rdy_i & biu_stb_ack_i;

  assign rsp_keep = ~(if_flush_i | if_flush_dly) & ~|discard;

  always_comb
  begin
    parcel_o.pc   = biu_adro_i;
    parcel_o.word = biu_q_i;
    // first valid parcel follows pc bit 1
    if (dcflush_rdy_i && biu_ack_i && rsp_keep)
      parcel_o.valid = {PARCELS{1'b1}} << biu_adro_i[1 +: SHIFT_W];
    else
      parcel_o.valid = '0;
    // with compressed instructions only byte offsets are misaligned
    if (HAS_RVC != 0)
      parcel_o.misaligned = biu_adro_i[0];
    else
      parcel_o.misaligned = |biu_adro_i[1:0];
    parcel_o.error = biu_err_i & rsp_keep;
  end

  ////////////////////
  // towards the bus interface
  ////////////////////

  // no new read in the flush cycle
  assign biu_stb_o  = dcflush_rdy_i & ~if_flush_i & if_req_i;
  assign biu_adri_o = if_req_data_i.pc;
  assign biu_prot_o = if_req_data_i.prot;
  // an address inside a word cannot start an incrementing burst
  assign biu_type_o = (|if_req_data_i.pc[1:0]) ? SINGLE : INCR;

endmodule

//--- logic/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen #(
  parameter fetch_pkg::addr_t RESET_PC = 32'h200
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // core control
  input  logic                   run_i,
  input  logic                   flush_i,
  input  fetch_pkg::addr_t       redirect_pc_i,
  input  fetch_pkg::prv_t        st_prv_i,
  // request handshake with the fetch controller
  input  logic                   if_ack_i,
  output logic                   if_req_o,
  output fetch_pkg::fetch_req_t  req_o
);

  import fetch_pkg::*;

  ////////////////////
  // program counter
  ////////////////////

  // current fetch address
  addr_t pc_q;
  // next word boundary after pc_q
  addr_t pc_next_word;

  // clear the parcel offset, then step one word
  assign pc_next_word = {pc_q[XLEN-1:2] + 1'b1, 2'b00};

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pc_q <= RESET_PC;
    end
    else if (flush_i)
    begin
      // redirect wins over a pending acknowledge
      pc_q <= redirect_pc_i;
    end
    else if (if_ack_i)
    begin
      // request taken, move on
      pc_q <= pc_next_word;
    end
  end

  ////////////////////
  // request side
  ////////////////////

  // request is held until acknowledged since pc_q only moves on if_ack_i
  assign if_req_o = run_i;

  always_comb
  begin
    req_o.pc             = pc_q;
    // always an instruction access
    req_o.prot.instr     = 1'b1;
    // user mode fetches are marked unprivileged
    req_o.prot.priv      = (st_prv_i != PRV_U);
    // no instruction cache behind this path
    req_o.prot.cacheable = 1'b0;
  end

endmodule

//--- logic/fetch_pkg.sv
package fetch_pkg;

  ////////////////////
  // widths
  ////////////////////

  // data and address width of the fetch path
  localparam int unsigned XLEN        = 32;
  localparam int unsigned PARCEL_SIZE = 16;
  // 16-bit parcels per instruction word
  localparam int unsigned PARCELS     = XLEN / PARCEL_SIZE;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] word_t;

  ////////////////////
  // privilege and bus encodings
  ////////////////////

  typedef logic [1:0] prv_t;

  localparam prv_t PRV_U = 2'b00;
  localparam prv_t PRV_M = 2'b11;

  // protection attributes of one bus access
  typedef struct packed {
    // 1 for instruction, 0 for data
    logic instr;
    // 1 for privileged, 0 for user
    logic priv;
    logic cacheable;
  } biu_prot_t;

  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10,
    DWORD = 2'b11
  } biu_size_t;

  // AHB style burst kind
  typedef enum logic {
    SINGLE = 1'b0,
    INCR   = 1'b1
  } biu_type_t;

  ////////////////////
  // bundles
  ////////////////////

  // sequencer request towards the fetch controller
  typedef struct packed {
    addr_t     pc;
    biu_prot_t prot;
  } fetch_req_t;

  // external read bus request, btype carries the burst kind
  typedef struct packed {
    logic      valid;
    addr_t     adr;
    biu_size_t size;
    biu_type_t btype;
    biu_prot_t prot;
  } bus_req_t;

  // external read bus response strobe
  typedef struct packed {
    logic  valid;
    logic  err;
    word_t data;
  } bus_rsp_t;

  // parcel bundle handed to the decoder side
  typedef struct packed {
    addr_t              pc;
    word_t              word;
    logic [PARCELS-1:0] valid;
    logic               misaligned;
    logic               error;
  } fetch_parcel_t;

endpackage
